/* bench/whac_vectors.txt */
# K <cycles since the last action> <scan code in hex>
# E <round score> <high score>, checked once game_over is high
K 5 26
K 190 1b
K 2 1b
K 8 2b
K 25 34
K 20 2b
K 10 23
E 3 3
K 3 2d
K 4 16
K 570 1b
K 2 1b
E 1 3
K 3 2d
K 4 1e
K 380 1b
K 3 23
E 2 3

/* project.f */
design/whac_pkg.sv
design/game_fsm.sv
design/tick_timer.sv
design/mole_field.sv
design/hit_scorer.sv
design/score_display.sv
design/whac_top.sv
bench/whac_tb.sv

/* Bender.yml */
package:
  name: whac

sources:
  - design/whac_pkg.sv
  - design/game_fsm.sv
  - design/tick_timer.sv
  - design/mole_field.sv
  - design/hit_scorer.sv
  - design/score_display.sv
  - design/whac_top.sv
  - target: test
    files:
      - bench/whac_tb.sv

/* bench/whac_tb.sv */
`timescale 1ns/1ps

module whac_tb;

	localparam int ROUND_EDGES = whac_pkg::ROUND_SECONDS * whac_pkg::TICKS_PER_SECOND *
		whac_pkg::CYCLES_PER_TICK;
	localparam int EDGES_PER_SECOND = whac_pkg::TICKS_PER_SECOND * whac_pkg::CYCLES_PER_TICK;
	localparam int WAIT_LIMIT = 10000;	// cycles allowed for any one wait
	localparam int S_IDLE = 0;
	localparam int S_PLAY = 1;
	localparam int S_WRAP = 2;
	localparam int S_OVER = 3;

	logic                 clk;
	logic                 resetn;
	whac_pkg::key_event_t key_event;
	whac_pkg::mole_view_t mole_view;
	whac_pkg::score_t     score;
	whac_pkg::score_t     high_score;
	whac_pkg::seconds_t   seconds_left;
	logic                 game_over;
	whac_pkg::seg7_t      hex_lo;
	whac_pkg::seg7_t      hex_hi;

	// reference model of the game
	int          m_state;
	int          m_rc;		// edges since the start key was sampled
	int          m_period;		// clocks per mole step
	int          m_score;
	int          m_high;
	int          m_h [4];
	logic [3:0]  m_r;
	logic [23:0] m_pat [4];
	logic [3:0]  m_pend;		// lanes hit since the last step
	logic [15:0] lfsr;
	int          fail_count;
	logic [6:0]  seg_ref [0:15];

	whac_top DUT (
		.clk          (clk),
		.resetn       (resetn),
		.key_event    (key_event),
		.mole_view    (mole_view),
		.score        (score),
		.high_score   (high_score),
		.seconds_left (seconds_left),
		.game_over    (game_over),
		.hex_lo       (hex_lo),
		.hex_hi       (hex_hi)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_count++;
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	task automatic reset_lanes();
		m_h = '{0, 0, 0, 0};
		m_r = '0;
		m_pend = '0;
		m_pat[0] = whac_pkg::LANE_PATTERN_0;
		m_pat[1] = whac_pkg::LANE_PATTERN_1;
		m_pat[2] = whac_pkg::LANE_PATTERN_2;
		m_pat[3] = whac_pkg::LANE_PATTERN_3;
	endtask

	task automatic step_lanes();
		logic old_r;
		for (int i = 0; i < 4; i++) begin
			old_r = m_r[i];
			if (m_h[i] == 0) begin
				m_r[i] = m_pat[i][23];
				m_pat[i] = {m_pat[i][22:0], m_pat[i][23]};
			end else if (m_h[i] == 8) begin
				m_r[i] = 1'b0;
			end
			if (old_r && m_h[i] < 8)
				m_h[i]++;
			else if (!old_r && m_h[i] > 0)
				m_h[i]--;
		end
	endtask

	function automatic int lane_of(input logic [7:0] code);
		case (code)
			whac_pkg::KEY_LANE_0: return 0;
			whac_pkg::KEY_LANE_1: return 1;
			whac_pkg::KEY_LANE_2: return 2;
			whac_pkg::KEY_LANE_3: return 3;
			default: return -1;
		endcase
	endfunction

	// ------------------------------
	// per-cycle compare and model update
	// ------------------------------
	task automatic compare_outputs();
		whac_pkg::mole_view_t exp_view;
		int exp_sec;
		for (int i = 0; i < 4; i++)
			exp_view.heights[i] = m_h[i][3:0];
		exp_view.rising = m_r;
		if (m_state == S_PLAY)
			exp_sec = 30 - m_rc / EDGES_PER_SECOND;
		else if (m_state == S_WRAP)
			exp_sec = 0;	// reload happens one cycle later
		else
			exp_sec = 30;
		check_value("mole_view", mole_view, exp_view);
		check_value("score", score, m_score);
		check_value("high_score", high_score, m_high);
		check_value("seconds_left", seconds_left, exp_sec);
		check_value("game_over", game_over, m_state == S_OVER);
	endtask

	// moves the model across the coming edge
	task automatic advance_model();
		int e;
		int lane;
		int hits;
		case (m_state)
			S_IDLE: begin
				if (key_event.valid && (key_event.code == whac_pkg::KEY_DIFF_1 ||
					key_event.code == whac_pkg::KEY_DIFF_2 ||
					key_event.code == whac_pkg::KEY_DIFF_3)) begin
					if (key_event.code == whac_pkg::KEY_DIFF_1)
						m_period = 4 * whac_pkg::STEP_TICKS_EASY;
					else if (key_event.code == whac_pkg::KEY_DIFF_2)
						m_period = 4 * whac_pkg::STEP_TICKS_MID;
					else
						m_period = 4 * whac_pkg::STEP_TICKS_HARD;
					m_state = S_PLAY;
					m_rc = 0;
					m_pend = '0;
				end
			end
			S_PLAY: begin
				e = m_rc + 1;
				if (e == 1)
					m_score = 0;	// cleared once run is seen high
				lane = key_event.valid ? lane_of(key_event.code) : -1;
				if (lane >= 0 && (m_h[lane] == 8 || (m_h[lane] == 7 && m_r[lane])))
					m_pend[lane] = 1'b1;
				if (e % m_period == 0) begin
					hits = 0;
					for (int i = 0; i < 4; i++)
						hits += m_pend[i];
					m_score += hits;
					m_pend = '0;
					step_lanes();
				end
				if (e == ROUND_EDGES)
					m_state = S_WRAP;
				m_rc = e;
			end
			S_WRAP: begin
				if (m_score > m_high)
					m_high = m_score;
				reset_lanes();
				m_state = S_OVER;
			end
			default: begin
				if (key_event.valid && key_event.code == whac_pkg::KEY_RESTART)
					m_state = S_IDLE;
			end
		endcase
	endtask

	task automatic cycle();
		@(negedge clk);
		compare_outputs();
		advance_model();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
			cycle();
	endtask

	task automatic press_key(input logic [7:0] code);
		key_event.valid = 1'b1;
		key_event.code = code;
		cycle();
		key_event.valid = 1'b0;
		key_event.code = '0;
	endtask

	task automatic wait_game_over();
		int n;
		n = 0;
		while (!game_over) begin
			cycle();
			n++;
			if (n > WAIT_LIMIT) begin
				$display("Timed out waiting for game_over at %0t ns", $time);
				$display("Some tests failed");
				$fatal(1);
			end
		end
	endtask

	// ------------------------------
	// vector replay
	// ------------------------------
	initial begin
		int fd;
		int n;
		int wait_cycles;
		int exp_score;
		int exp_high;
		byte tag;
		logic [7:0] code;
		string rest;

		seg_ref = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
		key_event = '0;
		resetn = 1'b0;
		lfsr = 16'd50724;
		fail_count = 0;
		m_state = S_IDLE;
		m_rc = 0;
		m_period = 60;
		m_score = 0;
		m_high = 0;
		reset_lanes();

		repeat (10) @(posedge clk);
		#1;
		resetn = 1'b1;
		idle_cycles(3);	// quiet state after reset

		fd = $fopen("bench/whac_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/whac_vectors.txt");
			$display("Some tests failed");
			$fatal(1);
		end

		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1)
				break;
			if (tag == "#") begin
				n = $fgets(rest, fd);	// comment line
			end else if (tag == "K") begin
				n = $fscanf(fd, "%d %h", wait_cycles, code);
				idle_cycles(wait_cycles - 1 + random_bits(2));	// jitter 0..3
				press_key(code);
			end else if (tag == "E") begin
				n = $fscanf(fd, "%d %d", exp_score, exp_high);
				wait_game_over();
				check_value("round score", score, exp_score);
				check_value("round high_score", high_score, exp_high);
				check_value("model score", m_score, exp_score);
				check_value("hex_lo", hex_lo, seg_ref[exp_score[3:0]]);
				check_value("hex_hi", hex_hi, seg_ref[exp_score[7:4]]);
			end else begin
				$display("Unknown line tag in vector file at %0t ns", $time);
				$display("Some tests failed");
				$fatal(1);
			end
		end
		$fclose(fd);

		if (fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* design/whac_top.sv */
`timescale 1ns/1ps

module whac_top (
	input  logic                 clk,
	input  logic                 resetn,
	input  whac_pkg::key_event_t key_event,
	output whac_pkg::mole_view_t mole_view,
	output whac_pkg::score_t     score,
	output whac_pkg::score_t     high_score,
	output whac_pkg::seconds_t   seconds_left,
	output logic                 game_over,
	output whac_pkg::seg7_t      hex_lo,
	output whac_pkg::seg7_t      hex_hi
);

	whac_pkg::difficulty_t difficulty;
	logic run;		// high for the whole round
	logic round_end;	// one cycle after time_up
	logic step;
	logic time_up;

	// ------------------------------
	// control and timing
	// ------------------------------
	game_fsm u_fsm (
		.clk        (clk),
		.resetn     (resetn),
		.key_event  (key_event),
		.time_up    (time_up),
		.difficulty (difficulty),
		.run        (run),
		.round_end  (round_end),
		.game_over  (game_over)
	);

	tick_timer u_timer (
		.clk          (clk),
		.resetn       (resetn),
		.run          (run),
		.difficulty   (difficulty),
		.step         (step),
		.time_up      (time_up),
		.seconds_left (seconds_left)
	);

	// ------------------------------
	// play field and scoring
	// ------------------------------
	mole_field u_field (
		.clk       (clk),
		.resetn    (resetn),
		.run       (run),
		.step      (step),
		.mole_view (mole_view)
	);

	hit_scorer u_scorer (
		.clk        (clk),
		.resetn     (resetn),
		.run        (run),
		.step       (step),
		.round_end  (round_end),
		.key_event  (key_event),
		.mole_view  (mole_view),
		.score      (score),
		.high_score (high_score)
	);

	score_display u_display (
		.score  (score),
		.hex_lo (hex_lo),
		.hex_hi (hex_hi)
	);

endmodule

/* design/score_display.sv */
`timescale 1ns/1ps

module score_display (
	input  whac_pkg::score_t score,
	output whac_pkg::seg7_t  hex_lo,
	output whac_pkg::seg7_t  hex_hi
);

	// segment order g..a, a lit segment is 0
	function automatic whac_pkg::seg7_t seg7_of(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg7_of = 7'b100_0000;
			4'h1: seg7_of = 7'b111_1001;
			4'h2: seg7_of = 7'b010_0100;
			4'h3: seg7_of = 7'b011_0000;
			4'h4: seg7_of = 7'b001_1001;
			4'h5: seg7_of = 7'b001_0010;
			4'h6: seg7_of = 7'b000_0010;
			4'h7: seg7_of = 7'b111_1000;
			4'h8: seg7_of = 7'b000_0000;
			4'h9: seg7_of = 7'b001_1000;
			4'hA: seg7_of = 7'b000_1000;
			4'hB: seg7_of = 7'b000_0011;
			4'hC: seg7_of = 7'b100_0110;
			4'hD: seg7_of = 7'b010_0001;
			4'hE: seg7_of = 7'b000_0110;
			4'hF: seg7_of = 7'b000_1110;
			default: seg7_of = 7'b111_1111;	// blank
		endcase
	endfunction

	assign hex_lo = seg7_of(score[3:0]);
	assign hex_hi = seg7_of(score[7:4]);

endmodule

/* design/hit_scorer.sv */
`timescale 1ns/1ps

module hit_scorer (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 run,
	input  logic                 step,
	input  logic                 round_end,
	input  whac_pkg::key_event_t key_event,
	input  whac_pkg::mole_view_t mole_view,
	output whac_pkg::score_t     score,
	output whac_pkg::score_t     high_score
);

	whac_pkg::scan_code_t [whac_pkg::NUM_LANES-1:0] lane_codes;
	logic [whac_pkg::NUM_LANES-1:0] hittable;	// mole at or just below the top
	logic [whac_pkg::NUM_LANES-1:0] hits;		// latched hits this step
	logic [whac_pkg::NUM_LANES-1:0] hits_next;
	logic [2:0]                     hit_count;
	logic                           run_q;

	assign lane_codes = {
		whac_pkg::KEY_LANE_3,
		whac_pkg::KEY_LANE_2,
		whac_pkg::KEY_LANE_1,
		whac_pkg::KEY_LANE_0
	};

	// ------------------------------
	// hammer decode
	// ------------------------------
	always_comb begin
		hit_count = 3'd0;
		for (int i = 0; i < whac_pkg::NUM_LANES; i++) begin
			hittable[i] = (mole_view.heights[i] == whac_pkg::MOLE_TOP) ||
				(mole_view.heights[i] == whac_pkg::MOLE_TOP - 4'd1 && mole_view.rising[i]);
			hits_next[i] = hits[i] ||
				(key_event.valid && key_event.code == lane_codes[i] && hittable[i]);
			hit_count = hit_count + {2'b00, hits_next[i]};
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			hits <= '0;
			run_q <= 1'b0;
			score <= '0;
			high_score <= '0;
		end else begin
			run_q <= run;
			if (!run || step)
				hits <= '0;	// at most one point per lane per step
			else
				hits <= hits_next;

			if (run && !run_q)
				score <= '0;	// new round
			else if (run && step)
				score <= score + {5'd0, hit_count};

			if (round_end && score > high_score)
				high_score <= score;
		end
	end

	score_monotonic: assert property (
		@(posedge clk) disable iff (!resetn)
		run && $past(run_q) |-> score >= $past(score)
	);

endmodule

/* design/mole_field.sv */
`timescale 1ns/1ps

module mole_field (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 run,
	input  logic                 step,
	output whac_pkg::mole_view_t mole_view
);

	whac_pkg::height_t [whac_pkg::NUM_LANES-1:0]  heights;
	logic [whac_pkg::NUM_LANES-1:0]               rising;
	whac_pkg::pattern_t [whac_pkg::NUM_LANES-1:0] patterns;	// rotating, one per lane

	// ------------------------------
	// lane motion
	// ------------------------------
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			heights <= '0;
			rising <= '0;
			patterns <= {
				whac_pkg::LANE_PATTERN_3,
				whac_pkg::LANE_PATTERN_2,
				whac_pkg::LANE_PATTERN_1,
				whac_pkg::LANE_PATTERN_0
			};
		end else if (!run) begin
			heights <= '0;	// all moles hidden between rounds
			rising <= '0;
			patterns <= {
				whac_pkg::LANE_PATTERN_3,
				whac_pkg::LANE_PATTERN_2,
				whac_pkg::LANE_PATTERN_1,
				whac_pkg::LANE_PATTERN_0
			};
		end else if (step) begin
			for (int i = 0; i < whac_pkg::NUM_LANES; i++) begin
				// direction for the next step
				if (heights[i] == 4'd0) begin
					rising[i] <= patterns[i][23];	// hidden, ask the pattern
					patterns[i] <= {patterns[i][22:0], patterns[i][23]};
				end else if (heights[i] == whac_pkg::MOLE_TOP) begin
					rising[i] <= 1'b0;	// peaked, start sinking
				end

				// move by the direction already held
				if (rising[i] && heights[i] < whac_pkg::MOLE_TOP)
					heights[i] <= heights[i] + 4'd1;
				else if (!rising[i] && heights[i] != 4'd0)
					heights[i] <= heights[i] - 4'd1;
			end
		end
	end

	assign mole_view.heights = heights;
	assign mole_view.rising = rising;

	// ------------------------------
	// checks
	// ------------------------------
	for (genvar g = 0; g < whac_pkg::NUM_LANES; g++) begin : g_lane_chk
		height_in_range: assert property (
			@(posedge clk) disable iff (!resetn)
			heights[g] <= whac_pkg::MOLE_TOP
		);
	end

endmodule

/* design/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  run,
	input  whac_pkg::difficulty_t difficulty,
	output logic                  step,
	output logic                  time_up,
	output whac_pkg::seconds_t    seconds_left
);

	logic [$clog2(whac_pkg::CYCLES_PER_TICK)-1:0]  presc;	// clocks within a tick
	logic [$clog2(whac_pkg::TICKS_PER_SECOND)-1:0] sec_cnt;	// ticks within a second
	whac_pkg::step_len_t step_cnt;				// ticks within a step
	whac_pkg::step_len_t step_len;
	logic tick;
	logic sec_wrap;

	always_comb begin
		case (difficulty)
			2'd2:    step_len = whac_pkg::STEP_TICKS_MID;
			2'd3:    step_len = whac_pkg::STEP_TICKS_HARD;
			default: step_len = whac_pkg::STEP_TICKS_EASY;
		endcase
	end

	assign tick = (presc == whac_pkg::CYCLES_PER_TICK - 1);
	assign step = tick && (step_cnt == step_len - 4'd1);
	assign sec_wrap = tick && (sec_cnt == whac_pkg::TICKS_PER_SECOND - 1);
	assign time_up = sec_wrap && (seconds_left == 5'd1);	// last second ends

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			presc <= '0;
			step_cnt <= '0;
			sec_cnt <= '0;
			seconds_left <= whac_pkg::ROUND_SECONDS;
		end else if (!run) begin
			presc <= '0;	// every round starts aligned
			step_cnt <= '0;
			sec_cnt <= '0;
			seconds_left <= whac_pkg::ROUND_SECONDS;
		end else begin
			presc <= tick ? '0 : presc + 1'b1;
			if (tick)
				step_cnt <= step ? '0 : step_cnt + 4'd1;
			if (tick)
				sec_cnt <= sec_wrap ? '0 : sec_cnt + 1'b1;
			if (sec_wrap && seconds_left != 5'd0)
				seconds_left <= seconds_left - 5'd1;
		end
	end

	no_step_when_stopped: assert property (
		@(posedge clk) disable iff (!resetn)
		!run |-> !step
	);

endmodule

/* design/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
	input  logic                  clk,
	input  logic                  resetn,
	input  whac_pkg::key_event_t  key_event,
	input  logic                  time_up,
	output whac_pkg::difficulty_t difficulty,
	output logic                  run,
	output logic                  round_end,
	output logic                  game_over
);

	whac_pkg::game_state_t state;
	whac_pkg::game_state_t state_next;
	whac_pkg::difficulty_t key_diff;	// difficulty named by this key, 0 if none
	logic                  start_key;
	logic                  restart_key;

	// ------------------------------
	// key decode
	// ------------------------------
	always_comb begin
		key_diff = 2'd0;
		if (key_event.valid) begin
			case (key_event.code)
				whac_pkg::KEY_DIFF_1: key_diff = 2'd1;
				whac_pkg::KEY_DIFF_2: key_diff = 2'd2;
				whac_pkg::KEY_DIFF_3: key_diff = 2'd3;
				default:              key_diff = 2'd0;
			endcase
		end
	end

	assign start_key = (key_diff != 2'd0);
	assign restart_key = key_event.valid && (key_event.code == whac_pkg::KEY_RESTART);

	// ------------------------------
	// round sequencing
	// ------------------------------
	always_comb begin
		state_next = state;
		case (state)
			whac_pkg::idle:    if (start_key) state_next = whac_pkg::play;
			whac_pkg::play:    if (time_up) state_next = whac_pkg::wrap_up;
			whac_pkg::wrap_up: state_next = whac_pkg::over;
			whac_pkg::over:    if (restart_key) state_next = whac_pkg::idle;
			default:           state_next = whac_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= whac_pkg::idle;
			difficulty <= 2'd0;
		end else begin
			state <= state_next;
			if (state == whac_pkg::idle && start_key)
				difficulty <= key_diff;	// held until the next start
		end
	end

	assign run = (state == whac_pkg::play);
	assign round_end = (state == whac_pkg::wrap_up);
	assign game_over = (state == whac_pkg::over);

	// a round only ends right after the timer ran out
	round_end_after_time_up: assert property (
		@(posedge clk) disable iff (!resetn)
		round_end |-> (state == whac_pkg::wrap_up) && $past(time_up) && $past(run)
	);

endmodule

/* design/whac_pkg.sv */
package whac_pkg;

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic [7:0]  scan_code_t;	// ps/2 set 2 make code
	typedef logic [3:0]  height_t;		// 0 = hidden
	typedef logic [7:0]  score_t;
	typedef logic [4:0]  seconds_t;
	typedef logic [1:0]  difficulty_t;	// 0 = none chosen
	typedef logic [6:0]  seg7_t;		// active low, g..a
	typedef logic [23:0] pattern_t;		// one rise bit per emergence
	typedef logic [3:0]  step_len_t;	// frame ticks per mole step

	// ------------------------------
	// game constants
	// ------------------------------
	localparam int NUM_LANES = 4;
	localparam height_t MOLE_TOP = 4'd8;
	localparam int CYCLES_PER_TICK = 4;	// stands in for the 60 Hz divider
	localparam int TICKS_PER_SECOND = 60;
	localparam seconds_t ROUND_SECONDS = 5'd30;

	localparam step_len_t STEP_TICKS_EASY = 4'd15;
	localparam step_len_t STEP_TICKS_MID = 4'd10;
	localparam step_len_t STEP_TICKS_HARD = 4'd5;

	// key codes
	localparam scan_code_t KEY_DIFF_1 = 8'h16;	// '1'
	localparam scan_code_t KEY_DIFF_2 = 8'h1E;	// '2'
	localparam scan_code_t KEY_DIFF_3 = 8'h26;	// '3'
	localparam scan_code_t KEY_RESTART = 8'h2D;	// 'r'
	localparam scan_code_t KEY_LANE_0 = 8'h1B;	// 's'
	localparam scan_code_t KEY_LANE_1 = 8'h23;	// 'd'
	localparam scan_code_t KEY_LANE_2 = 8'h2B;	// 'f'
	localparam scan_code_t KEY_LANE_3 = 8'h34;	// 'g'

	// rise patterns, msb is used first
	localparam pattern_t LANE_PATTERN_0 = 24'b110000111100101100110000;
	localparam pattern_t LANE_PATTERN_1 = 24'b110011000110011110110011;
	localparam pattern_t LANE_PATTERN_2 = 24'b000110011011000111001100;
	localparam pattern_t LANE_PATTERN_3 = 24'b001101100110110011011011;

	// ------------------------------
	// state and bundles
	// ------------------------------
	typedef enum logic [1:0] {
		idle,
		play,
		wrap_up,	// one cycle for the high score compare
		over
	} game_state_t;

	typedef struct packed {
		logic       valid;	// one-cycle strobe
		scan_code_t code;
	} key_event_t;

	typedef struct packed {
		height_t [NUM_LANES-1:0] heights;
		logic [NUM_LANES-1:0]    rising;
	} mole_view_t;

endpackage
